/* hdl/max_pool_pkg.sv */
package max_pool_pkg;

	// pixel and run-time setting widths
	localparam int PIX_W = 8;
	localparam int DIM_W = 16; // map dims come in as value - 1

	// widest map the row buffer can hold
	localparam int MAX_W = 128;

	// one buffer entry per column pair
	localparam int BUF_DEPTH = MAX_W / 2;
	localparam int BUF_ADDR_W = $clog2(BUF_DEPTH);

	// unsigned feature map pixel
	typedef logic [PIX_W-1:0] pixel_t;

	// dimension setting or counter value
	typedef logic [DIM_W-1:0] dim_t;

	// column-pair index into the row buffer
	typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

	// block control states
	typedef enum logic
	{
		ST_IDLE = 1'b0, // waiting for start
		ST_RUN  = 1'b1  // frame in progress
	} ctrl_state_e;

endpackage

/* hdl/pool_pos_if.sv */
`timescale 1ns/1ps

// position of the next pixel to be accepted
interface pool_pos_if
	import max_pool_pkg::*;
();

	logic      x_odd;    // odd column
	logic      y_odd;    // odd row
	buf_addr_t pair_idx; // column / 2
	logic      last_pix; // final pixel of the frame

	modport counter
	(
		output x_odd,
		output y_odd,
		output pair_idx,
		output last_pix
	);

	modport ctrl
	(
		input last_pix
	);

	modport datapath
	(
		input x_odd,
		input y_odd,
		input pair_idx
	);

endinterface

/* hdl/pool_ctrl.sv */
`timescale 1ns/1ps

module pool_ctrl
	import max_pool_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start_i,   // start strobe, only seen while idle
	input  logic       pix_vld_i, // pixel strobe from the sender
	pool_pos_if.ctrl   pos,
	output logic       accept_o,  // pixel taken into the pipeline
	output logic       idle_o,
	output logic       done_o     // lines up with the final pooled output
);

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	logic        run;
	logic        frame_end;

	assign run = (state_q == ST_RUN);

	// no pixels after the final one until the next start
	assign accept_o = pix_vld_i & run & ~done_o;

	// final pixel goes in this cycle
	assign frame_end = accept_o & pos.last_pix;

	always_comb
	begin
		state_d = state_q;
		unique case (state_q)
			ST_IDLE:
			begin
				if (start_i)
					state_d = ST_RUN;
			end
			ST_RUN:
			begin
				// stay in run while the last output goes out
				if (done_o)
					state_d = ST_IDLE;
			end
			default:
			begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	// same latency as the max unit output register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			done_o <= 1'b0;
		else
			done_o <= frame_end;
	end

	assign idle_o = (state_q == ST_IDLE);

endmodule

/* hdl/pool_pos_counter.sv */
`timescale 1ns/1ps

module pool_pos_counter
	import max_pool_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start_i,   // clears the counters, loads the limits
	input  logic         accept_i,  // one accepted pixel
	input  dim_t         map_w_i,   // width - 1
	input  dim_t         map_h_i,   // height - 1
	input  dim_t         map_chn_i, // channels - 1
	pool_pos_if.counter  pos
);

	dim_t col_q;
	dim_t row_q;
	dim_t chn_q;
	dim_t w_lim_q;
	dim_t h_lim_q;
	dim_t c_lim_q;
	logic col_end;
	logic row_end;
	logic chn_end;

	// limits held for the whole frame
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			w_lim_q <= '0;
			h_lim_q <= '0;
			c_lim_q <= '0;
		end
		else if (start_i)
		begin
			w_lim_q <= map_w_i;
			h_lim_q <= map_h_i;
			c_lim_q <= map_chn_i;
		end
	end

	assign col_end = (col_q == w_lim_q);
	assign row_end = (row_q == h_lim_q);
	assign chn_end = (chn_q == c_lim_q);

	// raster order, columns fastest
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			col_q <= '0;
			row_q <= '0;
			chn_q <= '0;
		end
		else if (start_i)
		begin
			col_q <= '0;
			row_q <= '0;
			chn_q <= '0;
		end
		else if (accept_i)
		begin
			if (!col_end)
				col_q <= col_q + 1'b1;
			else
			begin
				col_q <= '0;
				if (!row_end)
					row_q <= row_q + 1'b1;
				else
				begin
					row_q <= '0;
					// wraps to zero after the final pixel
					chn_q <= chn_end ? '0 : chn_q + 1'b1;
				end
			end
		end
	end

	assign pos.x_odd = col_q[0];
	assign pos.y_odd = row_q[0];
	assign pos.pair_idx = col_q[BUF_ADDR_W:1]; // width is at most MAX_W
	assign pos.last_pix = col_end & row_end & chn_end;

endmodule

/* hdl/pool_row_buf.sv */
`timescale 1ns/1ps

// horizontal maxima of the last even row, one entry per column pair
module pool_row_buf
	import max_pool_pkg::*;
(
	input  logic      clk,
	input  logic      wr_en_i,
	input  buf_addr_t addr_i,    // shared by write and read
	input  pixel_t    wr_data_i,
	output pixel_t    rd_data_o
);

	pixel_t mem [BUF_DEPTH];

	// write lands at the edge
	always_ff @(posedge clk)
	begin
		if (wr_en_i)
			mem[addr_i] <= wr_data_i;
	end

	// low latency read, no output register
	assign rd_data_o = mem[addr_i];

endmodule

/* hdl/pool_max_unit.sv */
`timescale 1ns/1ps

module pool_max_unit
	import max_pool_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          accept_i,
	input  pixel_t        pix_i,
	pool_pos_if.datapath  pos,
	input  logic          last_i,        // final pixel of the frame
	output logic          buf_wr_en_o,
	output buf_addr_t     buf_addr_o,
	output pixel_t        buf_wr_data_o,
	input  pixel_t        buf_rd_data_i, // same cycle as buf_addr_o
	output pixel_t        pool_o,
	output logic          pool_vld_o,
	output logic          pool_last_o
);

	pixel_t left_q;   // even column pixel of the current pair
	pixel_t h_max;    // max of the pair
	pixel_t win_max;  // max of the full 2x2 window
	logic   take_left;
	logic   pair_done;
	logic   win_done;

	function automatic pixel_t pix_max(input pixel_t a, input pixel_t b);
		return (a > b) ? a : b;
	endfunction

	assign take_left = accept_i & ~pos.x_odd;
	assign pair_done = accept_i & pos.x_odd;
	assign win_done = pair_done & pos.y_odd; // bottom right pixel of a window

	always_ff @(posedge clk)
	begin
		if (take_left)
			left_q <= pix_i;
	end

	assign h_max = pix_max(left_q, pix_i);
	assign win_max = pix_max(buf_rd_data_i, h_max);

	// even rows fill the buffer, odd rows read it back
	assign buf_wr_en_o = pair_done & ~pos.y_odd;
	assign buf_addr_o = pos.pair_idx;
	assign buf_wr_data_o = h_max;

	always_ff @(posedge clk)
	begin
		if (win_done)
			pool_o <= win_max;
	end

	// one strobe per window, one cycle after the pixel
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pool_vld_o <= 1'b0;
			pool_last_o <= 1'b0;
		end
		else
		begin
			pool_vld_o <= win_done;
			pool_last_o <= win_done & last_i;
		end
	end

endmodule

/* hdl/max_pool_top.sv */
`timescale 1ns/1ps

module max_pool_top
	import max_pool_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,

	// block control
	input  logic   start_i,
	output logic   idle_o,
	output logic   done_o,

	// run-time map size, each as value - 1
	input  dim_t   map_w_i,
	input  dim_t   map_h_i,
	input  dim_t   map_chn_i,

	// input pixel stream
	input  pixel_t pix_i,
	input  logic   pix_vld_i,

	// pooled output stream
	output pixel_t pool_o,
	output logic   pool_vld_o,
	output logic   pool_last_o
);

	logic      accept;
	logic      buf_wr_en;
	buf_addr_t buf_addr;
	pixel_t    buf_wr_data;
	pixel_t    buf_rd_data;

	pool_pos_if i_pos ();

	pool_ctrl i_ctrl
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.start_i   (start_i),
		.pix_vld_i (pix_vld_i),
		.pos       (i_pos.ctrl),
		.accept_o  (accept),
		.idle_o    (idle_o),
		.done_o    (done_o)
	);

	// start only counts while idle
	pool_pos_counter i_pos_counter
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.start_i   (start_i & idle_o),
		.accept_i  (accept),
		.map_w_i   (map_w_i),
		.map_h_i   (map_h_i),
		.map_chn_i (map_chn_i),
		.pos       (i_pos.counter)
	);

	pool_row_buf i_row_buf
	(
		.clk       (clk),
		.wr_en_i   (buf_wr_en),
		.addr_i    (buf_addr),
		.wr_data_i (buf_wr_data),
		.rd_data_o (buf_rd_data)
	);

	pool_max_unit i_max_unit
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.accept_i      (accept),
		.pix_i         (pix_i),
		.pos           (i_pos.datapath),
		.last_i        (i_pos.last_pix),
		.buf_wr_en_o   (buf_wr_en),
		.buf_addr_o    (buf_addr),
		.buf_wr_data_o (buf_wr_data),
		.buf_rd_data_i (buf_rd_data),
		.pool_o        (pool_o),
		.pool_vld_o    (pool_vld_o),
		.pool_last_o   (pool_last_o)
	);

endmodule

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps

// free running testbench clock
module tb_clk_gen
(
	output logic clk
);

	initial
		clk = 1'b0;

	always
		#2 clk = ~clk; // 4 ns period

endmodule

/* testbench/max_pool_assertions.sv */
`timescale 1ns/1ps

// output stream and block control protocol
module max_pool_assertions
(
	input logic clk,
	input logic rst_n,
	input logic idle_i,
	input logic done_i,
	input logic pool_vld_i,
	input logic pool_last_i
);

	last_has_vld: assert property (@(posedge clk) disable iff (!rst_n)
		pool_last_i |-> pool_vld_i)
		else $error("pool_last_o raised without pool_vld_o");

	// done marks the final output of a frame and nothing else
	done_is_last: assert property (@(posedge clk) disable iff (!rst_n)
		done_i == (pool_vld_i && pool_last_i))
		else $error("done_o does not line up with the final output");

	no_vld_idle: assert property (@(posedge clk) disable iff (!rst_n)
		idle_i |-> !pool_vld_i)
		else $error("pool_vld_o raised while idle");

	idle_after_done: assert property (@(posedge clk) disable iff (!rst_n)
		done_i |=> idle_i)
		else $error("idle_o did not rise after done_o");

endmodule

bind max_pool_top max_pool_assertions i_assertions
(
	.clk         (clk),
	.rst_n       (rst_n),
	.idle_i      (idle_o),
	.done_i      (done_o),
	.pool_vld_i  (pool_vld_o),
	.pool_last_i (pool_last_o)
);

/* testbench/tb_max_pool.sv */
`timescale 1ns/1ps

module tb_max_pool
	import max_pool_pkg::*;
();

	localparam int SEED = 32'h6a2b;
	localparam int N_FRAMES = 5;
	localparam int RST_CYCLES = 16;
	localparam int MAX_PIX = N_FRAMES * 3 * 8 * 16; // every frame at its largest

	logic   clk;
	logic   rst_n;
	logic   start_i;
	dim_t   map_w_i;
	dim_t   map_h_i;
	dim_t   map_chn_i;
	pixel_t pix_i;
	logic   pix_vld_i;
	logic   idle_o;
	logic   done_o;
	pixel_t pool_o;
	logic   pool_vld_o;
	logic   pool_last_o;

	int     seed = SEED;
	int     fw [N_FRAMES];
	int     fh [N_FRAMES];
	int     fc [N_FRAMES];
	int     fbase [N_FRAMES]; // first pixel of each frame
	pixel_t pix_mem [MAX_PIX]; // raster order, frames back to back
	int     gap_mem [MAX_PIX]; // idle cycles before each pixel
	pixel_t exp_q [$];
	logic   last_q [$];
	int     exp_frame_cnt = 0;
	logic   expect_idle = 1'b1;
	logic   idle_chk = 1'b0;
	int     frame_outs = 0;
	int     mismatch_errs = 0;
	int     other_errs = 0;
	int     cycle_cnt = 0;
	int     cycle_limit = 0;
	pixel_t exp_pix;
	logic   exp_last;

	tb_clk_gen i_clk_gen (.clk(clk));

	max_pool_top i_max_pool_top
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.start_i     (start_i),
		.idle_o      (idle_o),
		.done_o      (done_o),
		.map_w_i     (map_w_i),
		.map_h_i     (map_h_i),
		.map_chn_i   (map_chn_i),
		.pix_i       (pix_i),
		.pix_vld_i   (pix_vld_i),
		.pool_o      (pool_o),
		.pool_vld_o  (pool_vld_o),
		.pool_last_o (pool_last_o)
	);

	task automatic compare_pixel(input string name, input pixel_t got, input pixel_t want);
		if (got !== want)
		begin
			mismatch_errs++;
			$display("MISMATCH %s got %h expected %h at %0t", name, got, want, $time);
		end
	endtask

	task automatic verify_flag(input string name, input logic got, input logic want);
		if (got !== want)
		begin
			mismatch_errs++;
			$display("MISMATCH %s got %h expected %h at %0t", name, got, want, $time);
		end
	endtask

	task automatic match_count(input string name, input int got, input int want);
		if (got != want)
		begin
			mismatch_errs++;
			$display("MISMATCH %s got %h expected %h at %0t", name, got, want, $time);
		end
	endtask

	// largest of the four pixels in window (r, j) of plane c
	function automatic pixel_t window_max(input int f, input int c, input int r, input int j);
		pixel_t m;
		int     idx;
		m = '0;
		for (int dy = 0; dy < 2; dy++)
			for (int dx = 0; dx < 2; dx++)
			begin
				idx = fbase[f] + (c * fh[f] + 2 * r + dy) * fw[f] + 2 * j + dx;
				if (pix_mem[idx] > m)
					m = pix_mem[idx];
			end
		return m;
	endfunction

	task automatic make_frames();
		int n;
		n = 0;
		for (int f = 0; f < N_FRAMES; f++)
		begin
			fw[f] = 2 * (1 + $unsigned($random(seed)) % 8); // 2 .. 16
			fh[f] = 2 * (1 + $unsigned($random(seed)) % 4); // 2 .. 8
			fc[f] = 1 + $unsigned($random(seed)) % 3;
			fbase[f] = n;
			for (int p = 0; p < fw[f] * fh[f] * fc[f]; p++)
			begin
				pix_mem[n] = pixel_t'($random(seed));
				gap_mem[n] = $unsigned($random(seed)) % 4;
				cycle_limit += 2 * (1 + gap_mem[n]);
				n++;
			end
		end
		cycle_limit += 500;
	endtask

	task automatic load_expected(input int f);
		for (int c = 0; c < fc[f]; c++)
			for (int r = 0; r < fh[f] / 2; r++)
				for (int j = 0; j < fw[f] / 2; j++)
				begin
					exp_q.push_back(window_max(f, c, r, j));
					last_q.push_back(c == fc[f] - 1 && r == fh[f] / 2 - 1 && j == fw[f] / 2 - 1);
				end
	endtask

	task automatic run_frame(input int f);
		int n;
		n = fw[f] * fh[f] * fc[f];
		while (!idle_o)
			@(negedge clk);
		map_w_i = dim_t'(fw[f] - 1);
		map_h_i = dim_t'(fh[f] - 1);
		map_chn_i = dim_t'(fc[f] - 1);
		exp_frame_cnt = n / 4;
		load_expected(f);
		expect_idle = 1'b0;
		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		for (int p = 0; p < n; p++)
		begin
			repeat (gap_mem[fbase[f] + p])
				@(negedge clk);
			pix_i = pix_mem[fbase[f] + p];
			pix_vld_i = 1'b1;
			start_i = (f == 1 && p == 3); // a second start mid frame
			@(negedge clk);
			pix_vld_i = 1'b0;
			start_i = 1'b0;
		end
		while (!done_o)
			@(negedge clk);
		@(negedge clk);
	endtask

	// output monitor, outputs settle after the rising edge
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (expect_idle || idle_chk)
				verify_flag("idle_o", idle_o, 1'b1);
			idle_chk = done_o;
			if (pool_vld_o)
			begin
				frame_outs++;
				if (exp_q.size() == 0)
				begin
					other_errs++;
					$display("output strobe with no pooled value expected at %0t", $time);
				end
				else
				begin
					exp_pix = exp_q.pop_front();
					exp_last = last_q.pop_front();
					compare_pixel("pool_o", pool_o, exp_pix);
					verify_flag("pool_last_o", pool_last_o, exp_last);
					verify_flag("done_o", done_o, exp_last);
				end
			end
			else
				verify_flag("done_o", done_o, 1'b0);
			if (done_o)
			begin
				match_count("outputs per frame", frame_outs, exp_frame_cnt);
				frame_outs = 0;
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
		begin
			$display("timeout after %0d cycles, the frames did not complete", cycle_cnt);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial
	begin
		rst_n = 1'b0;
		start_i = 1'b0;
		map_w_i = '0;
		map_h_i = '0;
		map_chn_i = '0;
		pix_i = '0;
		pix_vld_i = 1'b0;
		make_frames();
		repeat (RST_CYCLES)
			@(negedge clk);
		rst_n = 1'b1;
		// pixels before any start go nowhere
		for (int i = 0; i < 6; i++)
		begin
			@(negedge clk);
			pix_i = pixel_t'($random(seed));
			pix_vld_i = 1'b1;
		end
		@(negedge clk);
		pix_vld_i = 1'b0;
		for (int f = 0; f < N_FRAMES; f++)
			run_frame(f);
		repeat (4)
			@(negedge clk);
		@(posedge clk);
		$display("errors: %0d mismatches, %0d other, %0d expected outputs missing",
			mismatch_errs, other_errs, exp_q.size());
		if (mismatch_errs == 0 && other_errs == 0 && exp_q.size() == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* all.f */
hdl/max_pool_pkg.sv
hdl/pool_pos_if.sv
hdl/pool_ctrl.sv
hdl/pool_pos_counter.sv
hdl/pool_row_buf.sv
hdl/pool_max_unit.sv
hdl/max_pool_top.sv
testbench/tb_clk_gen.sv
testbench/max_pool_assertions.sv
testbench/tb_max_pool.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_max_pool
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
